/* common/sound_pkg.sv */
package sound_pkg;

    // voice count and sample format
    localparam int NUM_VOICES = 3;
    localparam int SAMPLE_W = 8;
    localparam int PHASE_W = 6;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // clocks per sine step, zero means silent
    localparam int PITCH_W = 16;

    typedef logic [PITCH_W-1:0] pitch_t;

    // row length in note steps
    localparam int DUR_W = 16;

    typedef logic [DUR_W-1:0] dur_t;

    // pwm output level
    localparam int LEVEL_W = 10;
    localparam int LEVEL_MID = 512;

    typedef logic [LEVEL_W-1:0] level_t;

    localparam int SCORE_W = 16;

    typedef logic [SCORE_W-1:0] score_t;

    // cue tables
    localparam int ROW_W = 4;
    localparam int MUSIC_LEN = 8;
    localparam int JUMP_LEN = 6;
    localparam int SCORE_LEN = 4;

    typedef logic [ROW_W-1:0] row_t;

    // one table row, voice 0 pitch in the top bits and dur at the bottom
    localparam int NOTE_W = NUM_VOICES * PITCH_W + DUR_W;

    typedef logic [NOTE_W-1:0] note_t;

    typedef enum logic [1:0] {
        CUE_MUSIC,
        CUE_JUMP,
        CUE_SCORE
    } cue_t;

    typedef enum logic [1:0] {
        SEQ_FETCH,
        SEQ_LOAD,
        SEQ_PLAY
    } seq_state_t;

endpackage

/* common/note_row_if.sv */
`timescale 1ns/100ps

// row lookup, pitch and dur follow cue and row by one clock
interface note_row_if;

    sound_pkg::cue_t cue;
    sound_pkg::row_t row;
    sound_pkg::pitch_t pitch [sound_pkg::NUM_VOICES];
    sound_pkg::dur_t dur;

    modport seq (
        output cue,
        output row,
        input  pitch,
        input  dur
    );

    modport rom (
        input  cue,
        input  row,
        output pitch,
        output dur
    );

endinterface

/* design/tone_voice.sv */
`timescale 1ns/100ps

module tone_voice (
    input  logic clk,
    input  logic rst,
    input  sound_pkg::pitch_t pitch,
    output sound_pkg::sample_t sample
);

    sound_pkg::pitch_t div_cnt;
    logic [sound_pkg::PHASE_W-1:0] phase;

    // 64 points per period, kept as a quarter wave of 17 values
    function automatic sound_pkg::sample_t sine_at(logic [sound_pkg::PHASE_W-1:0] ph);
        logic [sound_pkg::PHASE_W-2:0] idx;
        sound_pkg::sample_t mag;
        idx = (ph[sound_pkg::PHASE_W-2:0] > 5'd16) ? 5'd0 - ph[sound_pkg::PHASE_W-2:0]
                                                   : ph[sound_pkg::PHASE_W-2:0];
        case (idx)
            5'd0:    mag = 8'sd0;
            5'd1:    mag = 8'sd7;
            5'd2:    mag = 8'sd13;
            5'd3:    mag = 8'sd19;
            5'd4:    mag = 8'sd25;
            5'd5:    mag = 8'sd30;
            5'd6:    mag = 8'sd35;
            5'd7:    mag = 8'sd40;
            5'd8:    mag = 8'sd45;
            5'd9:    mag = 8'sd49;
            5'd10:   mag = 8'sd52;
            5'd11:   mag = 8'sd55;
            5'd12:   mag = 8'sd58;
            5'd13:   mag = 8'sd60;
            5'd14:   mag = 8'sd62;
            default: mag = 8'sd63;
        endcase
        // second half of the period is the negated first half
        return ph[sound_pkg::PHASE_W-1] ? -mag : mag;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            phase <= '0;
            sample <= '0;
        end else if (pitch == '0) begin
            div_cnt <= '0;
            sample <= '0;
        end else if (div_cnt >= pitch) begin
            div_cnt <= '0;
            phase <= phase + 1'b1;
            sample <= sine_at(phase);
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

/* sequencer/cue_rom.sv */
`timescale 1ns/100ps

module cue_rom (
    input  logic clk,
    note_row_if.rom rows
);

    sound_pkg::note_t note;

    // row layout is voice 0, voice 1, voice 2 pitch, then dur in steps
    always_comb begin
        note = sound_pkg::note_t'(1);
        case (rows.cue)
            sound_pkg::CUE_MUSIC: begin
                case (rows.row)
                    4'd0:    note = {16'h1284, 16'h1605, 16'h1f23, 16'h010a};
                    4'd1:    note = {16'h1754, 16'h107f, 16'h2ea8, 16'h010a};
                    4'd2:    note = {16'h18b7, 16'h0f91, 16'h1f23, 16'h010a};
                    4'd3:    note = {16'h0ddf, 16'h1754, 16'h1754, 16'h010a};
                    4'd4:    note = {16'h0d17, 16'h1605, 16'h316e, 16'h010a};
                    4'd5:    note = {16'h14c8, 16'h0c5b, 16'h1f23, 16'h0085};
                    4'd6:    note = {16'h0c5b, 16'h14c8, 16'h18b7, 16'h0085};
                    4'd7:    note = {16'h14c8, 16'h0c5b, 16'h2ea8, 16'h0085};
                    default: note = sound_pkg::note_t'(1);
                endcase
            end
            sound_pkg::CUE_JUMP: begin
                // short rising figure
                case (rows.row)
                    4'd0:    note = {16'h0d17, 16'h045e, 16'h0299, 16'h0011};
                    4'd1:    note = {16'h0baa, 16'h022f, 16'h0000, 16'h0008};
                    4'd2:    note = {16'h022f, 16'h0b02, 16'h0000, 16'h0008};
                    4'd3:    note = {16'h09cf, 16'h02ea, 16'h01f2, 16'h0008};
                    4'd4:    note = {16'h02ea, 16'h01f2, 16'h0942, 16'h0008};
                    4'd5:    note = {16'h062d, 16'h020f, 16'h0000, 16'h0011};
                    default: note = sound_pkg::note_t'(1);
                endcase
            end
            sound_pkg::CUE_SCORE: begin
                case (rows.row)
                    4'd0:    note = {16'h04a1, 16'h0000, 16'h0000, 16'h0070};
                    4'd1:    note = {16'h04a1, 16'h03e4, 16'h02ea, 16'h0025};
                    4'd2:    note = {16'h03e4, 16'h02ea, 16'h0000, 16'h004b};
                    4'd3:    note = {16'h02ea, 16'h0299, 16'h01f2, 16'h0070};
                    default: note = sound_pkg::note_t'(1);
                endcase
            end
            default: begin
                note = sound_pkg::note_t'(1);
            end
        endcase
    end

    // one clock of latency
    always_ff @(posedge clk) begin
        for (int v = 0; v < sound_pkg::NUM_VOICES; v++) begin
            rows.pitch[v] <= note[sound_pkg::NOTE_W-1 - v*sound_pkg::PITCH_W -: sound_pkg::PITCH_W];
        end
        rows.dur <= note[sound_pkg::DUR_W-1:0];
    end

endmodule

/* sequencer/cue_sequencer.sv */
`timescale 1ns/100ps

module cue_sequencer #(
    parameter int unsigned STEP_CYCLES = 100000
) (
    input  logic clk,
    input  logic rst,
    input  logic jump,
    input  sound_pkg::score_t score,
    note_row_if.seq rows,
    output sound_pkg::pitch_t pitch [sound_pkg::NUM_VOICES],
    output sound_pkg::cue_t active_cue
);

    typedef logic [$clog2(STEP_CYCLES + 1)-1:0] step_t;

    sound_pkg::seq_state_t state;
    sound_pkg::score_t prev_score;
    logic jump_pend;
    logic score_pend;
    step_t step_timer;
    sound_pkg::dur_t dur_cnt;
    sound_pkg::row_t row;
    logic step_end;
    logic preempt;
    sound_pkg::cue_t want_cue;

    function automatic sound_pkg::row_t last_row(sound_pkg::cue_t c);
        case (c)
            sound_pkg::CUE_JUMP:  return sound_pkg::row_t'(sound_pkg::JUMP_LEN - 1);
            sound_pkg::CUE_SCORE: return sound_pkg::row_t'(sound_pkg::SCORE_LEN - 1);
            default:              return sound_pkg::row_t'(sound_pkg::MUSIC_LEN - 1);
        endcase
    endfunction

    // table address always follows the current cue and row
    assign rows.cue = active_cue;
    assign rows.row = row;

    assign step_end = (step_timer == step_t'(STEP_CYCLES - 1));

    // priority is jump, then score, then music
    assign want_cue = jump_pend ? sound_pkg::CUE_JUMP :
                      (score_pend ? sound_pkg::CUE_SCORE : sound_pkg::CUE_MUSIC);
    assign preempt = (jump_pend && active_cue != sound_pkg::CUE_JUMP) ||
                     (score_pend && active_cue == sound_pkg::CUE_MUSIC);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sound_pkg::SEQ_PLAY;
            active_cue <= sound_pkg::CUE_MUSIC;
            // a one-step dummy row on the last music row, so row 0 comes next
            row <= last_row(sound_pkg::CUE_MUSIC);
            dur_cnt <= sound_pkg::dur_t'(1);
            step_timer <= '0;
            prev_score <= '0;
            jump_pend <= 1'b0;
            score_pend <= 1'b0;
            for (int v = 0; v < sound_pkg::NUM_VOICES; v++) begin
                pitch[v] <= '0;
            end
        end else begin
            prev_score <= score;
            if (preempt) begin
                active_cue <= want_cue;
                row <= '0;
                state <= sound_pkg::SEQ_FETCH;
            end else begin
                case (state)
                    sound_pkg::SEQ_FETCH: begin
                        state <= sound_pkg::SEQ_LOAD;
                    end
                    sound_pkg::SEQ_LOAD: begin
                        for (int v = 0; v < sound_pkg::NUM_VOICES; v++) begin
                            pitch[v] <= rows.pitch[v];
                        end
                        dur_cnt <= rows.dur;
                        step_timer <= '0;
                        state <= sound_pkg::SEQ_PLAY;
                    end
                    default: begin
                        if (!step_end) begin
                            step_timer <= step_timer + 1'b1;
                        end else begin
                            step_timer <= '0;
                            if (dur_cnt != sound_pkg::dur_t'(1)) begin
                                dur_cnt <= dur_cnt - 1'b1;
                            end else if (row != last_row(active_cue)) begin
                                row <= row + 1'b1;
                                state <= sound_pkg::SEQ_FETCH;
                            end else begin
                                // cue finished, music just loops
                                row <= '0;
                                state <= sound_pkg::SEQ_FETCH;
                                if (active_cue == sound_pkg::CUE_JUMP) begin
                                    jump_pend <= 1'b0;
                                    active_cue <= score_pend ? sound_pkg::CUE_SCORE
                                                             : sound_pkg::CUE_MUSIC;
                                end else if (active_cue == sound_pkg::CUE_SCORE) begin
                                    score_pend <= 1'b0;
                                    active_cue <= sound_pkg::CUE_MUSIC;
                                end
                            end
                        end
                    end
                endcase
            end
            // a new request wins over a flag cleared on the same edge
            if (jump) begin
                jump_pend <= 1'b1;
            end
            if (score > prev_score) begin
                score_pend <= 1'b1;
            end
        end
    end

endmodule

/* design/mix_pwm.sv */
`timescale 1ns/100ps

module mix_pwm (
    input  logic clk,
    input  logic rst,
    input  sound_pkg::sample_t samples [sound_pkg::NUM_VOICES],
    output logic audio_pwm
);

    logic signed [sound_pkg::LEVEL_W+1:0] sum;
    logic signed [sound_pkg::LEVEL_W+1:0] offset;
    sound_pkg::level_t level;
    sound_pkg::level_t pwm_cnt;

    // three full-scale voices stay well inside the 12-bit sum
    always_comb begin
        sum = '0;
        for (int v = 0; v < sound_pkg::NUM_VOICES; v++) begin
            sum = sum + samples[v];
        end
    end

    // twice the sum around mid scale
    assign offset = (sum <<< 1) + (sound_pkg::LEVEL_W + 2)'(sound_pkg::LEVEL_MID);

    always_ff @(posedge clk) begin
        if (rst) begin
            level <= sound_pkg::level_t'(sound_pkg::LEVEL_MID);
            pwm_cnt <= '0;
            audio_pwm <= 1'b0;
        end else begin
            level <= sound_pkg::level_t'(offset);
            pwm_cnt <= pwm_cnt + 1'b1;
            audio_pwm <= (pwm_cnt < level);
        end
    end

endmodule

/* design/game_audio.sv */
`timescale 1ns/100ps

module game_audio #(
    parameter int unsigned STEP_CYCLES = 100000
) (
    input  logic clk,
    input  logic rst,
    input  logic jump,
    input  sound_pkg::score_t score,
    output logic audio_pwm,
    output sound_pkg::cue_t active_cue
);

    note_row_if rows ();

    sound_pkg::pitch_t pitch [sound_pkg::NUM_VOICES];
    sound_pkg::sample_t samples [sound_pkg::NUM_VOICES];

    cue_sequencer #(
        .STEP_CYCLES(STEP_CYCLES)
    ) u_seq (
        .clk(clk),
        .rst(rst),
        .jump(jump),
        .score(score),
        .rows(rows.seq),
        .pitch(pitch),
        .active_cue(active_cue)
    );

    cue_rom u_rom (
        .clk(clk),
        .rows(rows.rom)
    );

    // one sine voice per table column
    for (genvar v = 0; v < sound_pkg::NUM_VOICES; v++) begin : g_voice
        tone_voice u_voice (
            .clk(clk),
            .rst(rst),
            .pitch(pitch[v]),
            .sample(samples[v])
        );
    end

    mix_pwm u_mix (
        .clk(clk),
        .rst(rst),
        .samples(samples),
        .audio_pwm(audio_pwm)
    );

endmodule

/* testbench/game_audio_tests.svh */
// directed tests included inside game_audio_tb

task automatic pulse_jump();
    @(posedge clk);
    jump <= 1'b1;
    @(posedge clk);
    jump <= 1'b0;
endtask

// returns on the edge that latches the pending flag
task automatic set_score(input sound_pkg::score_t value);
    @(posedge clk);
    score <= value;
    @(posedge clk);
endtask

task automatic silence_after_reset();
    int errs;
    int highs;
    errs = error_count;
    @(negedge clk);
    compare_cue("active_cue", active_cue, sound_pkg::CUE_MUSIC);
    count_high(1024, highs);
    check_level("audio_pwm high count", sound_pkg::level_t'(highs),
                sound_pkg::level_t'(sound_pkg::LEVEL_MID));
    finish_test("silence_after_reset", errs);
endtask

task automatic music_sounds();
    int errs;
    int highs;
    int lo;
    int hi;
    bit saw_tone;
    errs = error_count;
    lo = sound_pkg::LEVEL_MID - 2 * sound_pkg::NUM_VOICES * PEAK;
    hi = sound_pkg::LEVEL_MID + 2 * sound_pkg::NUM_VOICES * PEAK;
    saw_tone = 1'b0;
    // first music row loads after one step plus the fetch
    repeat (STEP_CYCLES + 8) @(negedge clk);
    for (int w = 0; w < 32; w++) begin
        count_high(1024, highs);
        if (highs != sound_pkg::LEVEL_MID) begin
            saw_tone = 1'b1;
        end
        if (highs < lo || highs > hi) begin
            $display("window %0d high count %0d is outside %0d to %0d", w, highs, lo, hi);
            error_count++;
        end
    end
    if (!saw_tone) begin
        $display("audio_pwm stayed at the mid level through 32 windows of music");
        error_count++;
    end
    finish_test("music_sounds", errs);
endtask

task automatic jump_cue();
    int errs;
    int cycles;
    sound_pkg::cue_t seen;
    errs = error_count;
    pulse_jump();
    wait_cue_change(sound_pkg::CUE_MUSIC, CUE_LIMIT, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_JUMP);
    wait_cue_change(sound_pkg::CUE_JUMP, (JUMP_STEPS + 1) * STEP_CYCLES, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_MUSIC);
    if (cycles < JUMP_STEPS * STEP_CYCLES) begin
        $display("jump cue ended after %0d cycles, shorter than its rows", cycles);
        error_count++;
    end
    finish_test("jump_cue", errs);
endtask

task automatic score_cue();
    int errs;
    int cycles;
    int amount;
    sound_pkg::cue_t seen;
    errs = error_count;
    take_bits(8, amount);
    cur_score = cur_score + sound_pkg::score_t'(amount + 1);
    set_score(cur_score);
    wait_cue_change(sound_pkg::CUE_MUSIC, CUE_LIMIT, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_SCORE);
    wait_cue_change(sound_pkg::CUE_SCORE, (SCORE_STEPS + 1) * STEP_CYCLES, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_MUSIC);
    if (cycles < SCORE_STEPS * STEP_CYCLES) begin
        $display("score cue ended after %0d cycles, shorter than its rows", cycles);
        error_count++;
    end
    // an equal score is no rise
    set_score(cur_score);
    hold_cue(sound_pkg::CUE_MUSIC, STEP_CYCLES + CUE_LIMIT);
    take_bits(4, amount);
    amount = amount + 1;
    if (amount > int'(cur_score)) begin
        amount = int'(cur_score);
    end
    cur_score = cur_score - sound_pkg::score_t'(amount);
    set_score(cur_score);
    hold_cue(sound_pkg::CUE_MUSIC, STEP_CYCLES + CUE_LIMIT);
    finish_test("score_cue", errs);
endtask

task automatic priority_order();
    int errs;
    int cycles;
    int amount;
    sound_pkg::cue_t seen;
    errs = error_count;
    take_bits(8, amount);
    cur_score = cur_score + sound_pkg::score_t'(amount + 1);
    set_score(cur_score);
    wait_cue_change(sound_pkg::CUE_MUSIC, CUE_LIMIT, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_SCORE);
    repeat (2 * STEP_CYCLES) @(negedge clk);
    pulse_jump();
    wait_cue_change(sound_pkg::CUE_SCORE, CUE_LIMIT, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_JUMP);
    // the preempted score cue comes back after the jump
    wait_cue_change(sound_pkg::CUE_JUMP, (JUMP_STEPS + 1) * STEP_CYCLES, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_SCORE);
    wait_cue_change(sound_pkg::CUE_SCORE, (SCORE_STEPS + 1) * STEP_CYCLES, seen, cycles);
    compare_cue("active_cue", seen, sound_pkg::CUE_MUSIC);
    if (cycles < SCORE_STEPS * STEP_CYCLES) begin
        $display("resumed score cue ended after %0d cycles, shorter than its rows", cycles);
        error_count++;
    end
    finish_test("priority_order", errs);
endtask

/* testbench/game_audio_tb.sv */
`timescale 1ns/100ps

module game_audio_tb;

    localparam int unsigned STEP_CYCLES = 2048;
    // cycles after the flag edge for the cue to change
    localparam int CUE_LIMIT = 3;
    localparam int PEAK = 63;
    // summed row durations of the jump and score tables in steps
    localparam int JUMP_STEPS = 66;
    localparam int SCORE_STEPS = 336;

    logic clk = 1'b0;
    logic rst;
    logic jump;
    sound_pkg::score_t score;
    logic audio_pwm;
    sound_pkg::cue_t active_cue;

    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] lfsr_state = 32'h86ea20a5;
    sound_pkg::score_t cur_score = '0;

    game_audio #(
        .STEP_CYCLES(STEP_CYCLES)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .jump(jump),
        .score(score),
        .audio_pwm(audio_pwm),
        .active_cue(active_cue)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic compare_cue(input string what, input sound_pkg::cue_t got,
                               input sound_pkg::cue_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_level(input string what, input sound_pkg::level_t got,
                               input sound_pkg::level_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", what, got, exp);
            error_count++;
        end
    endtask

    // waits on falling edges until active_cue leaves from
    task automatic wait_cue_change(input sound_pkg::cue_t from, input int limit,
                                   output sound_pkg::cue_t seen, output int cycles);
        bit done;
        done = 1'b0;
        cycles = 0;
        seen = from;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (active_cue != from) begin
                seen = active_cue;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("timeout: active_cue did not leave %s within %0d cycles",
                     from.name(), limit);
            error_count++;
        end
    endtask

    task automatic hold_cue(input sound_pkg::cue_t exp, input int cycles);
        bit bad;
        bad = 1'b0;
        for (int n = 0; n < cycles && !bad; n++) begin
            @(negedge clk);
            if (active_cue != exp) begin
                bad = 1'b1;
                compare_cue("active_cue", active_cue, exp);
            end
        end
    endtask

    task automatic count_high(input int cycles, output int highs);
        highs = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (audio_pwm) begin
                highs++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("[pass] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s with %0d errors", name, error_count - errs_before);
        end
    endtask

    `include "game_audio_tests.svh"

    initial begin
        rst <= 1'b1;
        jump <= 1'b0;
        score <= '0;
        @(posedge clk);
        @(negedge clk);
        if (audio_pwm !== 1'b0) begin
            $display("ERROR audio_pwm got 0x%0h expected 0x0 during reset", audio_pwm);
            error_count++;
        end
        @(posedge clk);
        rst <= 1'b0;

        silence_after_reset();
        music_sounds();
        jump_cue();
        score_cue();
        priority_order();

        $display("summary: %0d tests, %0d failing, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+testbench
common/sound_pkg.sv
common/note_row_if.sv
design/tone_voice.sv
sequencer/cue_rom.sv
sequencer/cue_sequencer.sv
design/mix_pwm.sv
design/game_audio.sv
testbench/game_audio_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the game audio testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f \
    --top-module game_audio_tb -o game_audio_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/game_audio_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
    exit 0
fi
exit 1
